// ==== ex_settings.svh ====
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Execute stage widths
////////////////////////////////////////////////////////////

// Data path width, one machine word
`define EX_XLEN 32

// Register file address width
// Six bits so both integer and extra register banks fit
`define EX_REG_ADDR_W 6

// Shift amount taken from the low bits of operand B
`define EX_SHAMT_W 5

// Full product width of the multiplier
`define EX_PROD_W (2 * `EX_XLEN)

`endif

// ==== ex_pkg.sv ====
`include "ex_settings.svh"

package ex_pkg;

  // One data word, operand or result
  typedef logic [`EX_XLEN-1:0] data_t;

  // Destination register address
  typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

  // ALU operations
  // Compares return their flag zero-extended as the result
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLL = 4'd5,
    ALU_SRL = 4'd6,
    ALU_SRA = 4'd7,
    ALU_LTS = 4'd8,
    ALU_LTU = 4'd9,
    ALU_GES = 4'd10,
    ALU_GEU = 4'd11,
    ALU_EQ  = 4'd12,
    ALU_NE  = 4'd13
  } alu_op_e;

  // Multiplier operations
  // MUL gives the low word, the rest the high word
  typedef enum logic [1:0] {
    MUL_MUL    = 2'd0,
    MUL_MULH   = 2'd1,
    MUL_MULHSU = 2'd2,
    MUL_MULHU  = 2'd3
  } mul_op_e;

  // Multiplier FSM state
  typedef enum logic {
    MULT_IDLE = 1'b0,
    MULT_HIGH = 1'b1
  } mult_state_e;

endpackage

// ==== ex_alu.sv ====
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::data_t   operand_a_i,
  input  ex_pkg::data_t   operand_b_i,
  output ex_pkg::data_t   result_o,
  output logic            comparison_result_o
);

  ////////////////////////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////////////////////////

  // Shift amount from the low bits of B
  logic [`EX_SHAMT_W-1:0] shamt;

  // Adder and subtractor
  ex_pkg::data_t sum;
  ex_pkg::data_t diff;

  // Shifter outputs
  ex_pkg::data_t shift_left;
  ex_pkg::data_t shift_right_log;
  ex_pkg::data_t shift_right_ari;

  // Raw compare flags
  logic lt_signed;
  logic lt_unsigned;
  logic equal;

  assign shamt = operand_b_i[`EX_SHAMT_W-1:0];

  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  assign shift_left      = operand_a_i << shamt;
  assign shift_right_log = operand_a_i >> shamt;
  // Arithmetic shift keeps the sign of A
  assign shift_right_ari = ex_pkg::data_t'($signed(operand_a_i) >>> shamt);

  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;
  assign equal       = operand_a_i == operand_b_i;

  ////////////////////////////////////////////////////////////
  // Branch comparison
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Non-compare operations never take a branch
    comparison_result_o = 1'b0;
    case (operator_i)
      ex_pkg::ALU_LTS: comparison_result_o = lt_signed;
      ex_pkg::ALU_LTU: comparison_result_o = lt_unsigned;
      ex_pkg::ALU_GES: comparison_result_o = ~lt_signed;
      ex_pkg::ALU_GEU: comparison_result_o = ~lt_unsigned;
      ex_pkg::ALU_EQ:  comparison_result_o = equal;
      ex_pkg::ALU_NE:  comparison_result_o = ~equal;
      default:         comparison_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    case (operator_i)
      ex_pkg::ALU_ADD: result_o = sum;
      ex_pkg::ALU_SUB: result_o = diff;
      ex_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL: result_o = shift_left;
      ex_pkg::ALU_SRL: result_o = shift_right_log;
      ex_pkg::ALU_SRA: result_o = shift_right_ari;
      // Set-less-than style: flag in bit 0
      ex_pkg::ALU_LTS,
      ex_pkg::ALU_LTU,
      ex_pkg::ALU_GES,
      ex_pkg::ALU_GEU,
      ex_pkg::ALU_EQ,
      ex_pkg::ALU_NE: begin
        result_o = {{(`EX_XLEN-1){1'b0}}, comparison_result_o};
      end
      // Unused encodings give zero
      default: result_o = '0;
    endcase
  end

endmodule

// ==== ex_mult.sv ====
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_mult (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            enable_i,
  input  ex_pkg::mul_op_e operator_i,
  input  ex_pkg::data_t   op_a_i,
  input  ex_pkg::data_t   op_b_i,
  input  logic            ex_ready_i,
  output ex_pkg::data_t   result_o,
  output logic            multicycle_o,
  output logic            ready_o
);

  ////////////////////////////////////////////////////////////
  // Product
  ////////////////////////////////////////////////////////////

  // Per-operand signedness from the operator
  logic signed_a;
  logic signed_b;

  // Operands widened by one bit so one signed multiply covers all cases
  logic signed [`EX_XLEN:0] op_a_ext;
  logic signed [`EX_XLEN:0] op_b_ext;

  // Full product, two guard bits above the useful 64
  logic signed [`EX_PROD_W+1:0] prod_full;

  // Registered product for the high-word operations
  logic [`EX_PROD_W-1:0] prod_q;

  // High-word request decoded from the operator
  logic is_high_op;

  // FSM
  ex_pkg::mult_state_e state_q;
  ex_pkg::mult_state_e state_d;
  logic                prod_load;

  // MULHSU: A signed, B unsigned
  assign signed_a = (operator_i == ex_pkg::MUL_MULH) | (operator_i == ex_pkg::MUL_MULHSU);
  assign signed_b = (operator_i == ex_pkg::MUL_MULH);

  assign op_a_ext = {signed_a & op_a_i[`EX_XLEN-1], op_a_i};
  assign op_b_ext = {signed_b & op_b_i[`EX_XLEN-1], op_b_i};

  // Low word is the same for any signedness
  assign prod_full = op_a_ext * op_b_ext;

  assign is_high_op = operator_i != ex_pkg::MUL_MUL;

  ////////////////////////////////////////////////////////////
  // High-product FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    prod_load = 1'b0;
    case (state_q)
      ex_pkg::MULT_IDLE: begin
        // First cycle of a high op, capture the product
        if (enable_i && is_high_op) begin
          prod_load = 1'b1;
          state_d   = ex_pkg::MULT_HIGH;
        end
      end
      ex_pkg::MULT_HIGH: begin
        // Leave only once the stage accepts the result
        if (ex_ready_i) begin
          state_d = ex_pkg::MULT_IDLE;
        end
      end
      default: state_d = ex_pkg::MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Product register, data only
  always_ff @(posedge clk) begin
    if (prod_load) begin
      prod_q <= prod_full[`EX_PROD_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Stall the stage during the capture cycle only
  assign ready_o      = ~(state_q == ex_pkg::MULT_IDLE && enable_i && is_high_op);
  assign multicycle_o = state_q == ex_pkg::MULT_HIGH;

  always_comb begin
    if (state_q == ex_pkg::MULT_HIGH) begin
      result_o = prod_q[`EX_PROD_W-1:`EX_XLEN];
    end else begin
      // MUL result straight from the multiplier
      result_o = prod_full[`EX_XLEN-1:0];
    end
  end

endmodule

// ==== ex_writeback.sv ====
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_writeback (
  input  logic              clk,
  input  logic              rst_n,

  // Unit enables from ID
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,

  // Results and data
  input  ex_pkg::data_t     alu_result_i,
  input  ex_pkg::data_t     mult_result_i,
  input  ex_pkg::data_t     csr_rdata_i,
  input  ex_pkg::data_t     lsu_rdata_i,
  input  ex_pkg::data_t     alu_operand_c_i,
  input  logic              alu_cmp_result_i,
  input  logic              mult_ready_i,

  // Register write controls
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,

  // Stall and branch
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              wb_ready_i,
  input  logic              branch_in_ex_i,

  // Forwarding port to ID
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::data_t     regfile_alu_wdata_fw_o,

  // LSU writeback port
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::data_t     regfile_wdata_wb_o,

  // To fetch
  output logic              branch_decision_o,
  output ex_pkg::data_t     jump_target_o,

  // Stage handshake
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  // All units done and WB can take data
  logic units_done;

  ////////////////////////////////////////////////////////////
  // Forwarding mux
  ////////////////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  always_comb begin
    // CSR wins, then multiplier, then ALU
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////////////////////////

  assign units_done = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve here, no need to wait for WB
  assign ex_ready_o = units_done | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_done;

  ////////////////////////////////////////////////////////////
  // EX/WB register, LSU port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end else begin
      if (ex_valid_o) begin
        // Faulting access never writes the register file
        regfile_we_wb_o <= regfile_we_i & ~lsu_err_i;
        if (regfile_we_i & ~lsu_err_i) begin
          regfile_waddr_wb_o <= regfile_waddr_i;
        end
      end else if (wb_ready_i) begin
        // Bubble, flush the pending write
        regfile_we_wb_o <= 1'b0;
      end
    end
  end

  // Load data arrives with the WB cycle
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // Branch decision and target to fetch
  assign branch_decision_o = alu_cmp_result_i;
  assign jump_target_o     = alu_operand_c_i;

endmodule

// ==== ex_stage.sv ====
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,

  // ALU from ID
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  ex_pkg::data_t     alu_operand_a_i,
  input  ex_pkg::data_t     alu_operand_b_i,
  input  ex_pkg::data_t     alu_operand_c_i,
  input  logic              alu_en_i,

  // Multiplier from ID
  input  ex_pkg::mul_op_e   mult_operator_i,
  input  ex_pkg::data_t     mult_operand_a_i,
  input  ex_pkg::data_t     mult_operand_b_i,
  input  logic              mult_en_i,
  output logic              mult_multicycle_o,

  // CSR and LSU
  input  logic              csr_access_i,
  input  ex_pkg::data_t     csr_rdata_i,
  input  logic              lsu_en_i,
  input  ex_pkg::data_t     lsu_rdata_i,

  // Register write controls
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              branch_in_ex_i,

  // Stall inputs
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              wb_ready_i,

  // Forwarding port
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::data_t     regfile_alu_wdata_fw_o,

  // LSU writeback port
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::data_t     regfile_wdata_wb_o,

  // To fetch
  output logic              branch_decision_o,
  output ex_pkg::data_t     jump_target_o,

  // Handshake
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  // Unit results
  ex_pkg::data_t alu_result;
  logic          alu_cmp_result;
  ex_pkg::data_t mult_result;
  logic          mult_ready;

  ////////////////////////////////////////////////////////////
  // Units
  ////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result)
  );

  // Stage ready closes the multiplier's high-word cycle
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ////////////////////////////////////////////////////////////
  // Writeback and handshake
  ////////////////////////////////////////////////////////////

  ex_writeback u_writeback (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .alu_operand_c_i        (alu_operand_c_i),
    .alu_cmp_result_i       (alu_cmp_result),
    .mult_ready_i           (mult_ready),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .branch_decision_o      (branch_decision_o),
    .jump_target_o          (jump_target_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

// ==== tb_ex_stage.sv ====
`timescale 1ns/1ps
`include "ex_settings.svh"

module tb_ex_stage;

  localparam int NUM_INSTR  = 3000;
  localparam int CLK_PERIOD = 10;

  logic              clk;
  logic              rst_n;

  // ID side
  ex_pkg::alu_op_e   alu_operator_i;
  ex_pkg::data_t     alu_operand_a_i;
  ex_pkg::data_t     alu_operand_b_i;
  ex_pkg::data_t     alu_operand_c_i;
  logic              alu_en_i;
  ex_pkg::mul_op_e   mult_operator_i;
  ex_pkg::data_t     mult_operand_a_i;
  ex_pkg::data_t     mult_operand_b_i;
  logic              mult_en_i;
  logic              csr_access_i;
  ex_pkg::data_t     csr_rdata_i;
  logic              lsu_en_i;
  logic              regfile_alu_we_i;
  ex_pkg::reg_addr_t regfile_alu_waddr_i;
  logic              regfile_we_i;
  ex_pkg::reg_addr_t regfile_waddr_i;
  logic              branch_in_ex_i;

  // LSU and WB side
  ex_pkg::data_t     lsu_rdata_i;
  logic              lsu_ready_ex_i;
  logic              lsu_err_i;
  logic              wb_ready_i;

  // DUT outputs
  logic              mult_multicycle_o;
  logic              regfile_alu_we_fw_o;
  ex_pkg::reg_addr_t regfile_alu_waddr_fw_o;
  ex_pkg::data_t     regfile_alu_wdata_fw_o;
  logic              regfile_we_wb_o;
  ex_pkg::reg_addr_t regfile_waddr_wb_o;
  ex_pkg::data_t     regfile_wdata_wb_o;
  logic              branch_decision_o;
  ex_pkg::data_t     jump_target_o;
  logic              ex_ready_o;
  logic              ex_valid_o;

  // Model copies of the multiplier FSM and the EX/WB register
  ex_pkg::mult_state_e   m_state;
  logic [`EX_PROD_W-1:0] m_prod_q;
  logic                  m_we_wb;
  ex_pkg::reg_addr_t     m_waddr_wb;

  // Expected values for the current cycle
  ex_pkg::data_t         exp_alu;
  logic                  exp_cmp;
  logic [`EX_PROD_W-1:0] exp_prod;
  ex_pkg::data_t         exp_mult_res;
  logic                  exp_mult_ready;
  logic                  exp_done;
  logic                  exp_ready;
  logic                  exp_valid;
  ex_pkg::data_t         exp_fw_data;

  integer seed;
  int     accepted;
  logic   take_new;

  ex_stage DUT (.*);

  ////////////////////////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Bound well above the worst stall per instruction
  initial begin
    #(20 * NUM_INSTR * CLK_PERIOD);
    $display("Timeout: the instruction stream did not complete in time");
    $display("Done: errors found");
    $fatal(1, "Watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Returns {compare flag, result}
  function automatic logic [`EX_XLEN:0] alu_model(
    input ex_pkg::alu_op_e op,
    input ex_pkg::data_t   a,
    input ex_pkg::data_t   b
  );
    logic [`EX_PROD_W-1:0] a_sx;
    logic [`EX_PROD_W-1:0] sh_tmp;
    ex_pkg::data_t         a_bias;
    ex_pkg::data_t         b_bias;
    ex_pkg::data_t         res;
    logic                  flag;
    logic                  is_cmp;
    a_sx   = {{`EX_XLEN{a[`EX_XLEN-1]}}, a};
    sh_tmp = a_sx >> b[`EX_SHAMT_W-1:0];
    // Flipping the sign bits turns a signed compare into an unsigned one
    a_bias = a ^ {1'b1, {(`EX_XLEN-1){1'b0}}};
    b_bias = b ^ {1'b1, {(`EX_XLEN-1){1'b0}}};
    res    = '0;
    flag   = 1'b0;
    is_cmp = op inside {ex_pkg::ALU_LTS, ex_pkg::ALU_LTU, ex_pkg::ALU_GES,
                        ex_pkg::ALU_GEU, ex_pkg::ALU_EQ, ex_pkg::ALU_NE};
    case (op)
      ex_pkg::ALU_ADD: res = a + b;
      ex_pkg::ALU_SUB: res = a - b;
      ex_pkg::ALU_AND: res = a & b;
      ex_pkg::ALU_OR:  res = a | b;
      ex_pkg::ALU_XOR: res = a ^ b;
      ex_pkg::ALU_SLL: res = a << b[`EX_SHAMT_W-1:0];
      ex_pkg::ALU_SRL: res = a >> b[`EX_SHAMT_W-1:0];
      ex_pkg::ALU_SRA: res = sh_tmp[`EX_XLEN-1:0];
      ex_pkg::ALU_LTS: flag = a_bias < b_bias;
      ex_pkg::ALU_LTU: flag = a < b;
      ex_pkg::ALU_GES: flag = a_bias >= b_bias;
      ex_pkg::ALU_GEU: flag = a >= b;
      ex_pkg::ALU_EQ:  flag = a == b;
      ex_pkg::ALU_NE:  flag = a != b;
      default:         res = '0;
    endcase
    if (is_cmp) begin
      res = {{(`EX_XLEN-1){1'b0}}, flag};
    end
    return {flag, res};
  endfunction

  // Product of 64-bit extended operands
  // Correct modulo 2^64 for any signedness
  function automatic logic [`EX_PROD_W-1:0] mult_model(
    input ex_pkg::mul_op_e op,
    input ex_pkg::data_t   a,
    input ex_pkg::data_t   b
  );
    logic [`EX_PROD_W-1:0] a_w;
    logic [`EX_PROD_W-1:0] b_w;
    a_w = {{`EX_XLEN{1'b0}}, a};
    b_w = {{`EX_XLEN{1'b0}}, b};
    if (op == ex_pkg::MUL_MULH || op == ex_pkg::MUL_MULHSU) begin
      a_w = {{`EX_XLEN{a[`EX_XLEN-1]}}, a};
    end
    if (op == ex_pkg::MUL_MULH) begin
      b_w = {{`EX_XLEN{b[`EX_XLEN-1]}}, b};
    end
    return a_w * b_w;
  endfunction

  task automatic compute_expected();
    {exp_cmp, exp_alu} = alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
    exp_prod = mult_model(mult_operator_i, mult_operand_a_i, mult_operand_b_i);
    // Only the capture cycle of a high op stalls
    exp_mult_ready = !(m_state == ex_pkg::MULT_IDLE && mult_en_i &&
                       mult_operator_i != ex_pkg::MUL_MUL);
    exp_mult_res = (m_state == ex_pkg::MULT_HIGH) ? m_prod_q[`EX_PROD_W-1:`EX_XLEN]
                                                 : exp_prod[`EX_XLEN-1:0];
    exp_done  = exp_mult_ready && lsu_ready_ex_i && wb_ready_i;
    exp_ready = exp_done || branch_in_ex_i;
    exp_valid = (alu_en_i || mult_en_i || csr_access_i || lsu_en_i) && exp_done;
    if (csr_access_i) begin
      exp_fw_data = csr_rdata_i;
    end else if (mult_en_i) begin
      exp_fw_data = exp_mult_res;
    end else if (alu_en_i) begin
      exp_fw_data = exp_alu;
    end else begin
      exp_fw_data = '0;
    end
  endtask

  // State update at the rising edge while inputs are stable
  task automatic advance_model();
    if (m_state == ex_pkg::MULT_IDLE) begin
      if (mult_en_i && mult_operator_i != ex_pkg::MUL_MUL) begin
        m_prod_q = exp_prod;
        m_state  = ex_pkg::MULT_HIGH;
      end
    end else if (exp_ready) begin
      m_state = ex_pkg::MULT_IDLE;
    end
    if (exp_valid) begin
      m_we_wb = regfile_we_i && !lsu_err_i;
      if (m_we_wb) begin
        m_waddr_wb = regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      m_we_wb = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic check_value(
    input string         name,
    input logic [31:0]   got,
    input logic [31:0]   exp
  );
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "Output mismatch on %s", name);
    end
  endtask

  task automatic check_outputs();
    check_value("regfile_alu_we_fw_o", 32'(regfile_alu_we_fw_o), 32'(regfile_alu_we_i));
    check_value("regfile_alu_waddr_fw_o", 32'(regfile_alu_waddr_fw_o),
                32'(regfile_alu_waddr_i));
    check_value("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp_fw_data);
    check_value("regfile_we_wb_o", 32'(regfile_we_wb_o), 32'(m_we_wb));
    check_value("regfile_waddr_wb_o", 32'(regfile_waddr_wb_o), 32'(m_waddr_wb));
    check_value("regfile_wdata_wb_o", regfile_wdata_wb_o, lsu_rdata_i);
    check_value("branch_decision_o", 32'(branch_decision_o), 32'(exp_cmp));
    check_value("jump_target_o", jump_target_o, alu_operand_c_i);
    check_value("ex_ready_o", 32'(ex_ready_o), 32'(exp_ready));
    check_value("ex_valid_o", 32'(ex_valid_o), 32'(exp_valid));
    check_value("mult_multicycle_o", 32'(mult_multicycle_o),
                32'(m_state == ex_pkg::MULT_HIGH));
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  function automatic ex_pkg::data_t random_word();
    random_word = $random(seed);
  endfunction

  // Corner values now and then for the compares and products
  function automatic ex_pkg::data_t random_operand();
    ex_pkg::data_t r;
    r = random_word();
    case (r[2:0])
      3'd0:    random_operand = '0;
      3'd1:    random_operand = '1;
      3'd2:    random_operand = 32'h8000_0000;
      3'd3:    random_operand = 32'h7fff_ffff;
      default: random_operand = random_word();
    endcase
  endfunction

  task automatic pick_instruction();
    ex_pkg::data_t r;
    ex_pkg::data_t r2;
    logic [15:0]   tmp16;
    r     = random_word();
    r2    = random_word();
    tmp16 = r[31:16] % 16'd14;
    alu_operator_i   = ex_pkg::alu_op_e'(tmp16[3:0]);
    alu_operand_a_i  = random_operand();
    alu_operand_b_i  = random_operand();
    // Equal operands so EQ and NE see both outcomes
    if (r[8:7] == 2'd0) begin
      alu_operand_b_i = alu_operand_a_i;
    end
    alu_operand_c_i     = random_word();
    mult_operator_i     = ex_pkg::mul_op_e'(r[5:4]);
    mult_operand_a_i    = random_operand();
    mult_operand_b_i    = random_operand();
    csr_rdata_i         = random_word();
    regfile_alu_we_i    = r[9];
    regfile_alu_waddr_i = r[15:10];
    regfile_we_i        = r2[0];
    regfile_waddr_i     = r2[6:1];
    {alu_en_i, mult_en_i, csr_access_i, lsu_en_i, branch_in_ex_i} = 5'b0;
    if (r[3:0] < 4'd6) begin
      alu_en_i = 1'b1;
    end else if (r[3:0] < 4'd8) begin
      // Branches carry compare operations only
      tmp16          = r[31:16] % 16'd6;
      alu_operator_i = ex_pkg::alu_op_e'(4'd8 + tmp16[3:0]);
      alu_en_i       = 1'b1;
      branch_in_ex_i = 1'b1;
    end else if (r[3:0] < 4'd11) begin
      mult_en_i = 1'b1;
    end else if (r[3:0] == 4'd11) begin
      csr_access_i = 1'b1;
    end else if (r[3:0] == 4'd12) begin
      lsu_en_i = 1'b1;
    end else if (r[3:0] < 4'd15) begin
      // Several units at once to exercise the forwarding priority
      {alu_en_i, mult_en_i, csr_access_i, lsu_en_i} = r2[27:24];
    end
  endtask

  // LSU and WB inputs change every cycle since ID does not hold them
  task automatic drive_side_inputs();
    ex_pkg::data_t r;
    r              = random_word();
    lsu_ready_ex_i = r[2:0] != 3'd0;
    wb_ready_i     = r[5:3] != 3'd0;
    lsu_err_i      = r[8:6] == 3'd0;
    lsu_rdata_i    = random_word();
  endtask

  initial begin
    seed                = 32'h18d11358;
    rst_n               = 1'b0;
    alu_operator_i      = ex_pkg::ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    alu_en_i            = 1'b0;
    mult_operator_i     = ex_pkg::MUL_MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_en_i           = 1'b0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    branch_in_ex_i      = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    wb_ready_i          = 1'b1;
    m_state             = ex_pkg::MULT_IDLE;
    m_prod_q            = '0;
    m_we_wb             = 1'b0;
    m_waddr_wb          = '0;
    accepted            = 0;
    take_new            = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (accepted < NUM_INSTR) begin
      // ID holds its inputs until the stage accepts them
      if (take_new) begin
        pick_instruction();
      end
      drive_side_inputs();
      // Sample 1 ns before the rising edge
      #(CLK_PERIOD/2 - 1);
      compute_expected();
      check_outputs();
      @(posedge clk);
      advance_model();
      take_new = exp_ready;
      if (exp_ready) begin
        accepted++;
      end
      @(negedge clk);
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_writeback.sv
ex_stage.sv
tb_ex_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it
# The exit status is the simulator's, non-zero on any $fatal

cd "$(dirname "$0")" &&
verilator --binary -f tb.f --top-module tb_ex_stage -o sim_ex_stage &&
./obj_dir/sim_ex_stage ||
{ echo "Simulation build or run failed"; exit 1; }
